// File: include/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Datapath widths
`define RV_XLEN       32
`define RV_REG_IDX_W  5
`define RV_INSN_W     32
`define RV_PC_STEP    4

// Major opcodes
`define RV_OP_IMM       7'b0010011
`define RV_OP_OP        7'b0110011
`define RV_OP_LUI       7'b0110111
`define RV_OP_BRANCH    7'b1100011
`define RV_OP_JAL       7'b1101111
`define RV_OP_JALR      7'b1100111
`define RV_OP_SYSTEM    7'b1110011
`define RV_OP_MISC_MEM  7'b0001111

// ALU funct3, shared by the immediate and register forms
`define RV_F3_ADD   3'b000
`define RV_F3_SLL   3'b001
`define RV_F3_SLT   3'b010
`define RV_F3_SLTU  3'b011
`define RV_F3_XOR   3'b100
`define RV_F3_SR    3'b101  // SRL or SRA, split by funct7
`define RV_F3_OR    3'b110
`define RV_F3_AND   3'b111

// Branch funct3
`define RV_F3_BEQ   3'b000
`define RV_F3_BNE   3'b001
`define RV_F3_BLT   3'b100
`define RV_F3_BGE   3'b101
`define RV_F3_BLTU  3'b110
`define RV_F3_BGEU  3'b111

`define RV_F3_JALR   3'b000
`define RV_F3_FENCE  3'b000

`define RV_F7_BASE  7'b0000000
`define RV_F7_ALT   7'b0100000  // SUB and SRA

`endif

// File: verilog/rv_pkg.sv
`include "rv_consts.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    ALU_PASS_B  // LUI
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
  } br_cond_e;

  typedef enum logic {
    WB_ALU,
    WB_LINK  // pc + 4 for JAL and JALR
  } wb_sel_e;

  // Decoded control for one instruction
  typedef struct packed {
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    imm;      // Already sign-extended
    logic     use_imm;  // ALU operand B from imm
    alu_op_e  alu_op;
    logic     rf_we;    // Never set for rd == x0
    wb_sel_e  wb_sel;
    logic     is_branch;
    br_cond_e br_cond;
    logic     is_jal;
    logic     is_jalr;
    logic     is_ecall;
  } ctrl_t;

  // Architectural write of the current instruction
  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    word_t    data;
  } retire_t;

endpackage

// File: verilog/insn_decode.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module insn_decode (
  input  rv_pkg::word_t insn,
  output rv_pkg::ctrl_t ctrl,
  output logic          illegal
);
  import rv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] f3;
  logic [6:0] f7;
  logic       sgn;
  logic       wr;      // Instruction writes rd
  logic       imm_f7_ok;
  logic       reg_f7_ok;
  word_t      imm_i, imm_b, imm_j, imm_u;

  assign opcode = insn[6:0];
  assign f3     = insn[14:12];
  assign f7     = insn[31:25];
  assign sgn    = insn[`RV_INSN_W-1];

  assign imm_i = {{20{sgn}}, insn[31:20]};
  assign imm_b = {{19{sgn}}, sgn, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{sgn}}, sgn, insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  // Shift immediates carry funct7 in the upper imm bits, the rest are free
  assign imm_f7_ok = (f3 == `RV_F3_SLL) ? (f7 == `RV_F7_BASE) :
                     (f3 == `RV_F3_SR)  ? (f7 == `RV_F7_BASE || f7 == `RV_F7_ALT) : 1'b1;
  assign reg_f7_ok = (f7 == `RV_F7_BASE) ||
                     (f7 == `RV_F7_ALT && (f3 == `RV_F3_ADD || f3 == `RV_F3_SR));

  function automatic alu_op_e alu_from_f3(input logic [2:0] fn, input logic alt,
                                          input logic is_reg);
    case (fn)
      `RV_F3_ADD:  return (alt && is_reg) ? ALU_SUB : ALU_ADD;  // SUB only in the R form
      `RV_F3_SLL:  return ALU_SLL;
      `RV_F3_SLT:  return ALU_SLT;
      `RV_F3_SLTU: return ALU_SLTU;
      `RV_F3_XOR:  return ALU_XOR;
      `RV_F3_SR:   return alt ? ALU_SRA : ALU_SRL;
      `RV_F3_OR:   return ALU_OR;
      default:     return ALU_AND;
    endcase
  endfunction

  always_comb begin
    ctrl           = '0;
    ctrl.rs1       = insn[19:15];
    ctrl.rs2       = insn[24:20];
    ctrl.rd        = insn[11:7];
    ctrl.imm       = imm_i;
    ctrl.alu_op    = ALU_ADD;
    ctrl.wb_sel    = WB_ALU;
    ctrl.br_cond   = BR_EQ;
    illegal        = 1'b0;
    wr             = 1'b0;
    case (opcode)
      `RV_OP_IMM: begin
        ctrl.use_imm = 1'b1;
        ctrl.alu_op  = alu_from_f3(f3, insn[30], 1'b0);
        illegal      = !imm_f7_ok;
        wr           = imm_f7_ok;
      end
      `RV_OP_OP: begin
        ctrl.alu_op = alu_from_f3(f3, insn[30], 1'b1);
        illegal     = !reg_f7_ok;
        wr          = reg_f7_ok;
      end
      `RV_OP_LUI: begin
        ctrl.imm     = imm_u;
        ctrl.use_imm = 1'b1;
        ctrl.alu_op  = ALU_PASS_B;
        wr           = 1'b1;
      end
      `RV_OP_BRANCH: begin
        ctrl.imm = imm_b;
        case (f3)
          `RV_F3_BEQ:  ctrl.br_cond = BR_EQ;
          `RV_F3_BNE:  ctrl.br_cond = BR_NE;
          `RV_F3_BLT:  ctrl.br_cond = BR_LT;
          `RV_F3_BGE:  ctrl.br_cond = BR_GE;
          `RV_F3_BLTU: ctrl.br_cond = BR_LTU;
          `RV_F3_BGEU: ctrl.br_cond = BR_GEU;
          default:     illegal = 1'b1;
        endcase
        ctrl.is_branch = !illegal;
      end
      `RV_OP_JAL: begin
        ctrl.imm    = imm_j;
        ctrl.is_jal = 1'b1;
        ctrl.wb_sel = WB_LINK;
        wr          = 1'b1;
      end
      `RV_OP_JALR: begin
        illegal      = (f3 != `RV_F3_JALR);
        ctrl.is_jalr = !illegal;
        ctrl.wb_sel  = WB_LINK;
        wr           = !illegal;
      end
      `RV_OP_SYSTEM: begin
        ctrl.is_ecall = (insn[31:7] == 25'd0);  // EBREAK and CSRs unsupported
        illegal       = !ctrl.is_ecall;
      end
      `RV_OP_MISC_MEM: illegal = (f3 != `RV_F3_FENCE);  // FENCE is a no-op
      default:         illegal = 1'b1;
    endcase
    ctrl.rf_we = wr && (ctrl.rd != '0);
  end

  // Illegal arms above must leave the write enable clear
  always_comb begin
    no_write_on_illegal_a: assert (!(illegal && ctrl.rf_we))
      else $error("insn_decode: write enabled for illegal insn %h", insn);
  end

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module reg_file (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     we,
  input  logic [`RV_REG_IDX_W-1:0] waddr,
  input  logic [`RV_XLEN-1:0]      wdata,
  input  logic [`RV_REG_IDX_W-1:0] raddr1,
  input  logic [`RV_REG_IDX_W-1:0] raddr2,
  output logic [`RV_XLEN-1:0]      rdata1,
  output logic [`RV_XLEN-1:0]      rdata2
);

  // x1..x31 only, x0 has no storage
  logic [`RV_XLEN-1:0] regs [31:1];

  always_ff @(posedge clk) begin
    for (int i = 1; i < 32; i++) begin
      if (rst) begin
        regs[i] <= '0;
      end else if (we && waddr == i) begin
        regs[i] <= wdata;
      end
    end
  end

  // Reads see the old value until the edge
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

  // Decode filters rd == x0, so no write reaches it
  no_x0_write_a: assert property (@(posedge clk) disable iff (rst)
    !(we && waddr == '0))
    else $error("reg_file: write enable with waddr x0");

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module alu (
  input  rv_pkg::alu_op_e op,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  output rv_pkg::word_t   result
);
  import rv_pkg::*;

  localparam int sh_w = $clog2(`RV_XLEN);

  logic [sh_w-1:0] shamt;
  logic            lt_s;
  logic            lt_u;

  assign shamt = b[sh_w-1:0];  // Only the low bits of b count
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;

  always_comb begin
    case (op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_SLL:    result = a << shamt;
      ALU_SLT:    result = {{(`RV_XLEN-1){1'b0}}, lt_s};
      ALU_SLTU:   result = {{(`RV_XLEN-1){1'b0}}, lt_u};
      ALU_XOR:    result = a ^ b;
      ALU_SRL:    result = a >> shamt;
      ALU_SRA:    result = word_t'($signed(a) >>> shamt);
      ALU_OR:     result = a | b;
      ALU_AND:    result = a & b;
      ALU_PASS_B: result = b;  // LUI, imm already shifted up
      default:    result = '0;
    endcase
  end

endmodule

// File: verilog/pc_unit.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module pc_unit (
  input  logic          clk,
  input  logic          rst,
  input  rv_pkg::ctrl_t ctrl,
  input  rv_pkg::word_t rs1_data,
  input  rv_pkg::word_t rs2_data,
  output rv_pkg::word_t pc,
  output rv_pkg::word_t link
);
  import rv_pkg::*;

  logic  taken;
  word_t br_target;  // Branch and JAL share pc + imm
  word_t jalr_sum;
  word_t next_pc;

  // Branch compare
  always_comb begin
    case (ctrl.br_cond)
      BR_EQ:   taken = (rs1_data == rs2_data);
      BR_NE:   taken = (rs1_data != rs2_data);
      BR_LT:   taken = ($signed(rs1_data) < $signed(rs2_data));
      BR_GE:   taken = ($signed(rs1_data) >= $signed(rs2_data));
      BR_LTU:  taken = (rs1_data < rs2_data);
      BR_GEU:  taken = (rs1_data >= rs2_data);
      default: taken = 1'b0;
    endcase
  end

  assign link      = pc + `RV_PC_STEP;
  assign br_target = pc + ctrl.imm;
  assign jalr_sum  = rs1_data + ctrl.imm;

  always_comb begin
    if (ctrl.is_jalr) begin
      next_pc = {jalr_sum[`RV_XLEN-1:1], 1'b0};  // Bit 0 dropped per ISA
    end else if (ctrl.is_jal || (ctrl.is_branch && taken)) begin
      next_pc = br_target;
    end else begin
      next_pc = link;  // Sequential, also illegal and ECALL
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= next_pc;
    end
  end

  // Offsets from decode and the program must keep fetch word aligned
  pc_aligned_a: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc_unit: misaligned pc %h", pc);

endmodule

// File: verilog/rv_core.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core (
  input  logic            clk,
  input  logic            rst,
  output rv_pkg::word_t   insn_addr,
  input  rv_pkg::word_t   insn,
  output rv_pkg::retire_t retire,
  output logic            halt,
  output logic            illegal
);
  import rv_pkg::*;

  ctrl_t ctrl;
  logic  dec_illegal;
  word_t rs1_data, rs2_data;
  word_t alu_b;
  word_t alu_result;
  word_t link;
  word_t wb_data;

  insn_decode u_decode (
    .insn    (insn),
    .ctrl    (ctrl),
    .illegal (dec_illegal)
  );

  reg_file u_rf (
    .clk    (clk),
    .rst    (rst),
    .we     (ctrl.rf_we),
    .waddr  (ctrl.rd),
    .wdata  (wb_data),
    .raddr1 (ctrl.rs1),
    .raddr2 (ctrl.rs2),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data)
  );

  assign alu_b = ctrl.use_imm ? ctrl.imm : rs2_data;

  alu u_alu (
    .op     (ctrl.alu_op),
    .a      (rs1_data),
    .b      (alu_b),
    .result (alu_result)
  );

  pc_unit u_pc (
    .clk      (clk),
    .rst      (rst),
    .ctrl     (ctrl),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .pc       (insn_addr),  // Fetch address is the PC
    .link     (link)
  );

  assign wb_data = (ctrl.wb_sel == WB_LINK) ? link : alu_result;

  // Status outputs stay low during reset
  assign retire.valid = ctrl.rf_we && !rst;
  assign retire.rd    = ctrl.rd;
  assign retire.data  = wb_data;
  assign halt         = ctrl.is_ecall && !rst;
  assign illegal      = dec_illegal && !rst;

  // ECALL never retires a register write
  halt_no_retire_a: assert property (@(posedge clk) disable iff (rst)
    !(halt && retire.valid))
    else $error("rv_core: halt with retire valid at pc %h", insn_addr);

endmodule

// File: verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int half_period  = 10,
  parameter int reset_cycles = 8
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1 rst = 1'b0;  // Released just after the edge like other inputs
  end

endmodule

// File: verification/tb_rv_core.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_rv_core;
  import rv_pkg::*;

  localparam int          num_insns  = 400;
  localparam int          max_cycles = 450;  // 8 reset + 400 insns + margin
  localparam logic [15:0] seed       = 16'd22219;

  logic    clk;
  logic    rst;
  word_t   insn_addr;
  word_t   insn;
  retire_t retire;
  logic    halt;
  logic    illegal;

  word_t       regs [32];  // Architectural model
  word_t       pc;
  logic [15:0] lfsr;
  int          cycles = 0;
  int          checks = 0;
  int          errors = 0;
  int          err_mark = 0;

  // Expected effect of the instruction on insn
  logic     exp_we;
  reg_idx_t exp_rd;
  word_t    exp_data;
  word_t    exp_pc;
  logic     exp_halt;
  logic     exp_ill;

  tb_clk_gen clk_gen_i (.clk(clk), .rst(rst));

  rv_core dut_i (
    .clk       (clk),
    .rst       (rst),
    .insn_addr (insn_addr),
    .insn      (insn),
    .retire    (retire),
    .halt      (halt),
    .illegal   (illegal)
  );

  always @(posedge clk) begin
    cycles++;
    if (cycles > max_cycles) begin
      $display("Timeout: run did not end within %0d cycles", max_cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  // RV32I integer op rules, alt picks SUB or SRA
  function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
    case (f3)
      `RV_F3_ADD:  return alt ? a - b : a + b;
      `RV_F3_SLL:  return a << b[4:0];
      `RV_F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      `RV_F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
      `RV_F3_XOR:  return a ^ b;
      `RV_F3_SR:   return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      `RV_F3_OR:   return a | b;
      default:     return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
      `RV_F3_BEQ:  return a == b;
      `RV_F3_BNE:  return a != b;
      `RV_F3_BLT:  return $signed(a) < $signed(b);
      `RV_F3_BGE:  return $signed(a) >= $signed(b);
      `RV_F3_BLTU: return a < b;
      default:     return a >= b;
    endcase
  endfunction

  task automatic check(input string name, input word_t expected, input word_t actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic report_test(input string name);
    $display("test %s finished, %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  // Builds one legal instruction and the model's expected result
  task automatic make_insn(output word_t w);
    logic [31:0] r;
    logic [2:0]  kind;
    logic [2:0]  f3;
    reg_idx_t    rd, rs1, rs2;
    logic [11:0] imm12;
    logic        alt;
    word_t       off;
    take_bits(3, r);
    kind = r[2:0];
    take_bits(3, r);
    rd = reg_idx_t'(r);  // x0..x7 for frequent dependencies
    take_bits(3, r);
    rs1 = reg_idx_t'(r);
    take_bits(3, r);
    rs2 = reg_idx_t'(r);
    take_bits(3, r);
    f3 = r[2:0];
    take_bits(1, r);
    alt = r[0];
    take_bits(12, r);
    imm12 = r[11:0];
    take_bits(5, r);
    off = {{25{r[4]}}, r[4:0], 2'b00};
    exp_we   = 1'b1;
    exp_rd   = rd;
    exp_pc   = pc + 32'd4;
    exp_halt = 1'b0;
    exp_ill  = 1'b0;
    case (kind)
      3'd0, 3'd1: begin
        if (f3 == `RV_F3_SLL) imm12[11:5] = 7'd0;
        else if (f3 == `RV_F3_SR) imm12[11:5] = {1'b0, alt, 5'd0};
        w        = {imm12, rs1, f3, rd, `RV_OP_IMM};
        exp_data = alu_model(f3, alt && (f3 == `RV_F3_SR), regs[rs1],
                             {{20{imm12[11]}}, imm12});
      end
      3'd2, 3'd3: begin
        if (f3 != `RV_F3_ADD && f3 != `RV_F3_SR) alt = 1'b0;
        w        = {1'b0, alt, 5'd0, rs2, rs1, f3, rd, `RV_OP_OP};
        exp_data = alu_model(f3, alt, regs[rs1], regs[rs2]);
      end
      3'd4: begin
        take_bits(20, r);
        w        = {r[19:0], rd, `RV_OP_LUI};
        exp_data = {r[19:0], 12'd0};
      end
      3'd5: begin
        if (f3[2:1] == 2'b01) f3[2] = 1'b1;  // No branch at funct3 2 or 3
        w      = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH};
        exp_we = 1'b0;
        if (branch_taken(f3, regs[rs1], regs[rs2])) exp_pc = pc + off;
      end
      3'd6: begin
        w        = {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
        exp_data = pc + 32'd4;
        exp_pc   = pc + off;
      end
      default: begin
        off[0]   = alt;  // Odd offset exercises the bit 0 clear
        w        = {off[11:0], 5'd0, `RV_F3_JALR, rd, `RV_OP_JALR};
        exp_data = pc + 32'd4;
        exp_pc   = {off[31:1], 1'b0};  // rs1 is x0
      end
    endcase
    if (rd == '0) exp_we = 1'b0;
  endtask

  // Called just after a rising edge, returns just after the next one
  task automatic step_insn(input string name, input word_t w);
    insn = w;
    @(negedge clk);
    check({name, " pc"}, pc, insn_addr);
    check({name, " retire valid"}, exp_we, retire.valid);
    check({name, " halt"}, exp_halt, halt);
    check({name, " illegal"}, exp_ill, illegal);
    if (exp_we) begin
      check({name, " retire rd"}, exp_rd, retire.rd);
      check({name, " retire data"}, exp_data, retire.data);
      regs[exp_rd] = exp_data;
    end
    pc = exp_pc;
    @(posedge clk);
    #1;
  endtask

  initial begin
    word_t w;
    word_t bad [4];
    word_t rst_insn [3];
    bad      = '{32'h0000_0000, 32'hFFFF_FFFF, 32'h0000_2083, 32'h4000_1093};
    rst_insn = '{32'h0050_0093, 32'h0000_0073, 32'h0000_0000};  // addi, ecall, illegal
    insn = 32'h0050_0093;  // addi x1, x0, 5
    lfsr = seed;
    pc   = '0;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end

    // A write, an ECALL and an illegal word, each masked while in reset
    foreach (rst_insn[i]) begin
      @(posedge clk);
      #1;
      insn = rst_insn[i];
      @(negedge clk);
      check("reset pc", 32'd0, insn_addr);
      check("reset retire valid", 32'd0, retire.valid);
      check("reset halt", 32'd0, halt);
      check("reset illegal", 32'd0, illegal);
    end
    wait (rst == 1'b0);
    report_test("reset_state");

    for (int n = 0; n < num_insns; n++) begin
      make_insn(w);
      step_insn("random", w);
    end
    report_test("random_stream");

    foreach (bad[i]) begin
      exp_we   = 1'b0;
      exp_halt = 1'b0;
      exp_ill  = 1'b1;
      exp_pc   = pc + 32'd4;
      step_insn("illegal", bad[i]);
    end
    report_test("illegal_opcodes");

    exp_we   = 1'b0;
    exp_halt = 1'b1;
    exp_ill  = 1'b0;
    exp_pc   = pc + 32'd4;
    step_insn("ecall", 32'h0000_0073);
    insn = 32'h0000_0013;  // NOP
    @(negedge clk);
    check("ecall next pc", pc, insn_addr);
    report_test("ecall_halt");

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+include
verilog/rv_pkg.sv
verilog/insn_decode.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/pc_unit.sv
verilog/rv_core.sv
verification/tb_clk_gen.sv
verification/tb_rv_core.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_rv_core
FILELIST   ?= vlog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)
	@! grep -q "SIMULATION FAILED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
